// File: hdl/memMapPkg.sv
// Widths, address map, ANTIC and POKEY register offsets, ANTIC update codes
// CPU bus, address union and register bank types
`default_nettype none

package memMapPkg;

  localparam int DataW    = 8;
  localparam int AddrW    = 16;
  localparam int RamAddrW = 14;

  // Region limits
  localparam logic [AddrW-1:0] RamTop  = 16'h4000; // Below is work RAM
  localparam logic [AddrW-1:0] CartTop = 16'hC000; // Cartridge up to here, registers above

  localparam logic [7:0] AnticPage = 8'hD4;
  localparam logic [7:0] PokeyPage = 8'hE8;

  // ANTIC offsets
  localparam logic [7:0] AnticDmactl = 8'h00;
  localparam logic [7:0] AnticChactl = 8'h01;
  localparam logic [7:0] AnticDlistl = 8'h02;
  localparam logic [7:0] AnticDlisth = 8'h03;
  localparam logic [7:0] AnticHscrol = 8'h04;
  localparam logic [7:0] AnticVscrol = 8'h05;
  localparam logic [7:0] AnticPmbase = 8'h07;
  localparam logic [7:0] AnticChbase = 8'h09;
  localparam logic [7:0] AnticWsync  = 8'h0A;
  localparam logic [7:0] AnticVcount = 8'h0B; // Read only
  localparam logic [7:0] AnticPenh   = 8'h0C; // Read only
  localparam logic [7:0] AnticPenv   = 8'h0D; // Read only
  localparam logic [7:0] AnticNmien  = 8'h0E;
  localparam logic [7:0] AnticNmist  = 8'h0F;

  // POKEY offsets, reads share the same numbers
  localparam logic [7:0] PokeyAudf1  = 8'h00;
  localparam logic [7:0] PokeyAudc1  = 8'h01;
  localparam logic [7:0] PokeyAudf2  = 8'h02;
  localparam logic [7:0] PokeyAudc2  = 8'h03;
  localparam logic [7:0] PokeyAudf3  = 8'h04;
  localparam logic [7:0] PokeyAudc3  = 8'h05;
  localparam logic [7:0] PokeyAudf4  = 8'h06;
  localparam logic [7:0] PokeyAudc4  = 8'h07;
  localparam logic [7:0] PokeyAudctl = 8'h08;
  localparam logic [7:0] PokeyStimer = 8'h09; // Strobe only
  localparam logic [7:0] PokeySkrest = 8'h0A;
  localparam logic [7:0] PokeyPotgo  = 8'h0B; // Strobe only
  localparam logic [7:0] PokeySerout = 8'h0D;
  localparam logic [7:0] PokeyIrqen  = 8'h0E;
  localparam logic [7:0] PokeySkctl  = 8'h0F;

  localparam int StrobeCycles = 8;
  localparam int NumStrobes   = 2;
  localparam int StrobePotgo  = 0;
  localparam int StrobeStimer = 1;

  // ANTIC side update codes
  localparam logic [2:0] AnticNone   = 3'd0;
  localparam logic [2:0] AnticDlL    = 3'd1;
  localparam logic [2:0] AnticDlLH   = 3'd2;
  localparam logic [2:0] AnticDlLNmi = 3'd4;
  localparam logic [2:0] AnticDlAll  = 3'd5;
  localparam logic [2:0] AnticNmi    = 3'd6;

  // Flat for region decode, page and offset for register decode
  typedef union packed {
    logic [AddrW-1:0] raw;
    struct packed {
      logic [7:0] page;
      logic [7:0] offset;
    } split;
  } cpuAddrT;

  typedef struct packed {
    cpuAddrT          addr;
    logic             write;
    logic [DataW-1:0] wrData;
  } cpuBusT;

  typedef struct packed {
    logic [2:0] update;
    logic [7:0] dlistl;
    logic [7:0] dlisth;
    logic [7:0] nmist;
    logic [7:0] vcount;
    logic [7:0] penh;
    logic [7:0] penv;
  } anticChipT;

  typedef struct packed {
    logic [7:0] dmactl;
    logic [7:0] chactl;
    logic [7:0] dlistl;
    logic [7:0] dlisth;
    logic [7:0] hscrol;
    logic [7:0] vscrol;
    logic [7:0] pmbase;
    logic [7:0] chbase;
    logic [7:0] wsync;
    logic [7:0] nmien;
    logic [7:0] nmist;
  } anticRegsT;

  typedef struct packed {
    logic [7:0] pot0;
    logic [7:0] pot1;
    logic [7:0] pot2;
    logic [7:0] pot3;
    logic [7:0] pot4;
    logic [7:0] pot5;
    logic [7:0] pot6;
    logic [7:0] pot7;
    logic [7:0] allpot;
    logic [7:0] kbcode;
    logic [7:0] random;
    logic [7:0] serin;
    logic [7:0] irqst;
    logic [7:0] skstat;
  } pokeyInT;

  typedef struct packed {
    logic [7:0] audf1;
    logic [7:0] audc1;
    logic [7:0] audf2;
    logic [7:0] audc2;
    logic [7:0] audf3;
    logic [7:0] audc3;
    logic [7:0] audf4;
    logic [7:0] audc4;
    logic [7:0] audctl;
    logic [7:0] skrest;
    logic [7:0] serout;
    logic [7:0] irqen;
    logic [7:0] skctl;
  } pokeyRegsT;

endpackage

`default_nettype wire

// File: hdl/workRam.sv
// 16 K by 8 work RAM, synchronous read
`default_nettype none
`timescale 1ns/1ps

module workRam (
  input  wire logic                           Fclk,
  input  wire logic                           write,
  input  wire logic [memMapPkg::RamAddrW-1:0] addr,
  input  wire logic [memMapPkg::DataW-1:0]    wrData,
  output logic [memMapPkg::DataW-1:0]         rdData
);
  import memMapPkg::*;

  logic [DataW-1:0] mem [2**RamAddrW];

  always_ff @(posedge Fclk) begin
    if (write) begin
      mem[addr] <= wrData;
      rdData    <= wrData; // Write-first
    end else begin
      rdData <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/strobeStretcher.sv
// One-cycle request to fixed-width strobe
`default_nettype none
`timescale 1ns/1ps

module strobeStretcher #(
  parameter int Cycles = memMapPkg::StrobeCycles
) (
  input  wire logic Fclk,
  input  wire logic rst,
  input  wire logic req,
  output logic      strobe
);

  logic [$clog2(Cycles+1)-1:0] count; // Cycles left high

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (req) begin
      count <= Cycles[$clog2(Cycles+1)-1:0]; // Restart on every request
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign strobe = count != '0;

endmodule

`default_nettype wire

// File: hdl/busSteer.sv
// Region decode, write steering and CPU read data mux
`default_nettype none
`timescale 1ns/1ps

module busSteer (
  input  wire logic                          Fclk,
  input  wire logic                          rst,
  input  wire memMapPkg::cpuBusT             cpu,
  input  wire logic [memMapPkg::DataW-1:0]   ramData,  // Already one cycle late
  input  wire logic [memMapPkg::DataW-1:0]   cartData,
  input  wire logic [memMapPkg::DataW-1:0]   anticRd,
  input  wire logic [memMapPkg::DataW-1:0]   pokeyRd,
  output logic                               ramWrite,
  output logic                               regWrite,
  output logic [memMapPkg::DataW-1:0]        rdData
);
  import memMapPkg::*;

  logic             isRam;
  logic             isCart;
  logic             isReg;
  logic             ramSelQ;
  logic             cartSelQ;
  logic [DataW-1:0] cartQ;
  logic [DataW-1:0] regQ;

  assign isRam  = cpu.addr.raw < RamTop;
  assign isCart = !isRam && (cpu.addr.raw < CartTop);
  assign isReg  = cpu.addr.raw >= CartTop;

  // Cartridge writes go nowhere
  assign ramWrite = cpu.write && isRam;
  assign regWrite = cpu.write && isReg;

  // Line region and non-RAM data up with the RAM output
  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      ramSelQ  <= 1'b0;
      cartSelQ <= 1'b0;
      cartQ    <= '0;
      regQ     <= '0;
    end else begin
      ramSelQ  <= isRam;
      cartSelQ <= isCart;
      cartQ    <= cartData;
      regQ     <= anticRd | pokeyRd; // Off-page blocks drive zero
    end
  end

  assign rdData = ramSelQ  ? ramData :
                  cartSelQ ? cartQ   :
                             regQ;

endmodule

`default_nettype wire

// File: hdl/anticRegs.sv
// ANTIC register bank with CPU writes, chip-side updates and read-back
`default_nettype none
`timescale 1ns/1ps

module anticRegs (
  input  wire logic                        Fclk,
  input  wire logic                        rst,
  input  wire memMapPkg::cpuBusT           cpu,
  input  wire logic                        regWrite,
  input  wire memMapPkg::anticChipT        chip,
  output memMapPkg::anticRegsT             regs,
  output logic [memMapPkg::DataW-1:0]      rdData
);
  import memMapPkg::*;

  logic       onPage;
  logic       cpuWr;
  logic [7:0] offset;
  logic       ldDlL;   // Chip loads DLISTL
  logic       ldDlH;   // Chip loads DLISTH
  logic       ldNmi;   // Chip loads NMIST
  logic [7:0] vcount;
  logic [7:0] penh;
  logic [7:0] penv;

  assign onPage = cpu.addr.split.page == AnticPage;
  assign offset = cpu.addr.split.offset;
  assign cpuWr  = regWrite && onPage;

  // Update code to load flags
  always_comb begin
    case (chip.update)
      AnticNone:   {ldDlL, ldDlH, ldNmi} = 3'b000;
      AnticDlL:    {ldDlL, ldDlH, ldNmi} = 3'b100;
      AnticDlLH:   {ldDlL, ldDlH, ldNmi} = 3'b110;
      AnticDlLNmi: {ldDlL, ldDlH, ldNmi} = 3'b101;
      AnticDlAll:  {ldDlL, ldDlH, ldNmi} = 3'b111;
      AnticNmi:    {ldDlL, ldDlH, ldNmi} = 3'b001;
      default:     {ldDlL, ldDlH, ldNmi} = 3'b000; // Spare codes
    endcase
  end

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      regs   <= '0;
      vcount <= '0;
      penh   <= '0;
      penv   <= '0;
    end else begin
      vcount <= chip.vcount; // Sampled every cycle
      penh   <= chip.penh;
      penv   <= chip.penv;
      if (ldDlL) regs.dlistl <= chip.dlistl;
      if (ldDlH) regs.dlisth <= chip.dlisth;
      if (ldNmi) regs.nmist  <= chip.nmist;
      // CPU write comes last so it wins over the chip
      if (cpuWr) begin
        case (offset)
          AnticDmactl: regs.dmactl <= cpu.wrData;
          AnticChactl: regs.chactl <= cpu.wrData;
          AnticDlistl: regs.dlistl <= cpu.wrData;
          AnticDlisth: regs.dlisth <= cpu.wrData;
          AnticHscrol: regs.hscrol <= cpu.wrData;
          AnticVscrol: regs.vscrol <= cpu.wrData;
          AnticPmbase: regs.pmbase <= cpu.wrData;
          AnticChbase: regs.chbase <= cpu.wrData;
          AnticWsync:  regs.wsync  <= cpu.wrData;
          AnticNmien:  regs.nmien  <= cpu.wrData;
          AnticNmist:  regs.nmist  <= cpu.wrData;
          default: ;  // Read-only or unused offset
        endcase
      end
    end
  end

  // Read-back, zero off page
  always_comb begin
    rdData = '0;
    if (onPage) begin
      case (offset)
        AnticDmactl: rdData = regs.dmactl;
        AnticChactl: rdData = regs.chactl;
        AnticDlistl: rdData = regs.dlistl;
        AnticDlisth: rdData = regs.dlisth;
        AnticHscrol: rdData = regs.hscrol;
        AnticVscrol: rdData = regs.vscrol;
        AnticPmbase: rdData = regs.pmbase;
        AnticChbase: rdData = regs.chbase;
        AnticWsync:  rdData = regs.wsync;
        AnticVcount: rdData = vcount;
        AnticPenh:   rdData = penh;
        AnticPenv:   rdData = penv;
        AnticNmien:  rdData = regs.nmien;
        AnticNmist:  rdData = regs.nmist;
        default:     rdData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/pokeyRegs.sv
// POKEY write registers, read pass-through and strobe requests
`default_nettype none
`timescale 1ns/1ps

module pokeyRegs (
  input  wire logic                          Fclk,
  input  wire logic                          rst,
  input  wire memMapPkg::cpuBusT             cpu,
  input  wire logic                          regWrite,
  input  wire memMapPkg::pokeyInT            pokeyIn,
  output memMapPkg::pokeyRegsT               regs,
  output logic [memMapPkg::NumStrobes-1:0]   strobeReq,
  output logic [memMapPkg::DataW-1:0]        rdData
);
  import memMapPkg::*;

  logic       onPage;
  logic       cpuWr;
  logic [7:0] offset;

  assign onPage = cpu.addr.split.page == PokeyPage;
  assign offset = cpu.addr.split.offset;
  assign cpuWr  = regWrite && onPage;

  // Same cycle as the write, stretchers register them
  always_comb begin
    strobeReq               = '0;
    strobeReq[StrobePotgo]  = cpuWr && (offset == PokeyPotgo);
    strobeReq[StrobeStimer] = cpuWr && (offset == PokeyStimer);
  end

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (cpuWr) begin
      case (offset)
        PokeyAudf1:  regs.audf1  <= cpu.wrData;
        PokeyAudc1:  regs.audc1  <= cpu.wrData;
        PokeyAudf2:  regs.audf2  <= cpu.wrData;
        PokeyAudc2:  regs.audc2  <= cpu.wrData;
        PokeyAudf3:  regs.audf3  <= cpu.wrData;
        PokeyAudc3:  regs.audc3  <= cpu.wrData;
        PokeyAudf4:  regs.audf4  <= cpu.wrData;
        PokeyAudc4:  regs.audc4  <= cpu.wrData;
        PokeyAudctl: regs.audctl <= cpu.wrData;
        PokeySkrest: regs.skrest <= cpu.wrData;
        PokeySerout: regs.serout <= cpu.wrData;
        PokeyIrqen:  regs.irqen  <= cpu.wrData;
        PokeySkctl:  regs.skctl  <= cpu.wrData;
        default: ; // STIMER and POTGO only strobe
      endcase
    end
  end

  // Reads come straight from the chip
  always_comb begin
    rdData = '0;
    if (onPage) begin
      case (offset)
        PokeyAudf1:  rdData = pokeyIn.pot0;
        PokeyAudc1:  rdData = pokeyIn.pot1;
        PokeyAudf2:  rdData = pokeyIn.pot2;
        PokeyAudc2:  rdData = pokeyIn.pot3;
        PokeyAudf3:  rdData = pokeyIn.pot4;
        PokeyAudc3:  rdData = pokeyIn.pot5;
        PokeyAudf4:  rdData = pokeyIn.pot6;
        PokeyAudc4:  rdData = pokeyIn.pot7;
        PokeyAudctl: rdData = pokeyIn.allpot;
        PokeyStimer: rdData = pokeyIn.kbcode;
        PokeySkrest: rdData = pokeyIn.random;
        PokeySerout: rdData = pokeyIn.serin;
        PokeyIrqen:  rdData = pokeyIn.irqst;
        PokeySkctl:  rdData = pokeyIn.skstat;
        default:     rdData = '0; // B, C and above F
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/memoryMap.sv
// Memory map top level
// Bus steering, work RAM, ANTIC and POKEY banks, strobe stretchers
`default_nettype none
`timescale 1ns/1ps

module memoryMap (
  input  wire logic                          Fclk,
  input  wire logic                          rst,
  input  wire memMapPkg::cpuBusT             cpu,
  input  wire logic [memMapPkg::DataW-1:0]   cartData,
  input  wire memMapPkg::anticChipT          anticChip,
  input  wire memMapPkg::pokeyInT            pokeyIn,
  output logic [memMapPkg::DataW-1:0]        rdData,
  output memMapPkg::anticRegsT               anticRegs,
  output memMapPkg::pokeyRegsT               pokeyRegs,
  output logic [memMapPkg::NumStrobes-1:0]   strobes
);
  import memMapPkg::*;

  logic                  ramWrite;
  logic                  regWrite;
  logic [DataW-1:0]      ramData;
  logic [DataW-1:0]      anticRd;
  logic [DataW-1:0]      pokeyRd;
  logic [NumStrobes-1:0] strobeReq;

  busSteer u_busSteer (
    .Fclk     (Fclk),
    .rst      (rst),
    .cpu      (cpu),
    .ramData  (ramData),
    .cartData (cartData),
    .anticRd  (anticRd),
    .pokeyRd  (pokeyRd),
    .ramWrite (ramWrite),
    .regWrite (regWrite),
    .rdData   (rdData)
  );

  workRam u_workRam (
    .Fclk   (Fclk),
    .write  (ramWrite),
    .addr   (cpu.addr.raw[RamAddrW-1:0]), // Low 16 K
    .wrData (cpu.wrData),
    .rdData (ramData)
  );

  anticRegs u_anticRegs (
    .Fclk     (Fclk),
    .rst      (rst),
    .cpu      (cpu),
    .regWrite (regWrite),
    .chip     (anticChip),
    .regs     (anticRegs),
    .rdData   (anticRd)
  );

  pokeyRegs u_pokeyRegs (
    .Fclk      (Fclk),
    .rst       (rst),
    .cpu       (cpu),
    .regWrite  (regWrite),
    .pokeyIn   (pokeyIn),
    .regs      (pokeyRegs),
    .strobeReq (strobeReq),
    .rdData    (pokeyRd)
  );

  // POTGO and STIMER strobes go straight out
  for (genvar i = 0; i < NumStrobes; i++) begin : gStretch
    strobeStretcher u_strobeStretcher (
      .Fclk   (Fclk),
      .rst    (rst),
      .req    (strobeReq[i]),
      .strobe (strobes[i])
    );
  end

endmodule

`default_nettype wire

// File: tests/memoryMapTb.sv
// Memory map testbench
// LFSR stimulus, RAM, ANTIC and POKEY reference model, concurrent checks
`default_nettype none
`timescale 1ns/1ps

module memoryMapTb;
  import memMapPkg::*;

  localparam int TimeoutCycles = 3000; // About twice the stimulus length

  logic                  Fclk;
  logic                  rst;
  cpuBusT                cpu;
  logic [DataW-1:0]      cartData;
  anticChipT             anticChip;
  pokeyInT               pokeyIn;
  logic [DataW-1:0]      rdData;
  anticRegsT             anticRegs;
  pokeyRegsT             pokeyRegs;
  logic [NumStrobes-1:0] strobes;

  // Reference model state
  logic [7:0]            ramModel [16384];
  logic [7:0]            anticShadow [16]; // Indexed by register offset
  logic [7:0]            pokeyShadow [16];
  logic [7:0]            vcountQ;
  logic [7:0]            penhQ;
  logic [7:0]            penvQ;
  int                    strobeCnt [NumStrobes];
  logic [7:0]            expRd;
  anticRegsT             expAntic;
  pokeyRegsT             expPokey;
  logic [NumStrobes-1:0] expStrobes;

  logic [31:0]           lfsr = 32'ha211e405;
  int                    cycleCount = 0;

  memoryMap u_memoryMap (
    .Fclk      (Fclk),
    .rst       (rst),
    .cpu       (cpu),
    .cartData  (cartData),
    .anticChip (anticChip),
    .pokeyIn   (pokeyIn),
    .rdData    (rdData),
    .anticRegs (anticRegs),
    .pokeyRegs (pokeyRegs),
    .strobes   (strobes)
  );

  initial Fclk = 1'b0;
  always #5 Fclk = ~Fclk;

  task automatic abortRun();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]}; // One step per bit
    end
  endtask

  function automatic logic [7:0] pokeyRead(input logic [7:0] off);
    case (off)
      8'h00: return pokeyIn.pot0;
      8'h01: return pokeyIn.pot1;
      8'h02: return pokeyIn.pot2;
      8'h03: return pokeyIn.pot3;
      8'h04: return pokeyIn.pot4;
      8'h05: return pokeyIn.pot5;
      8'h06: return pokeyIn.pot6;
      8'h07: return pokeyIn.pot7;
      8'h08: return pokeyIn.allpot;
      8'h09: return pokeyIn.kbcode;
      8'h0A: return pokeyIn.random;
      8'h0D: return pokeyIn.serin;
      8'h0E: return pokeyIn.irqst;
      8'h0F: return pokeyIn.skstat;
      default: return 8'h00; // B, C and unclaimed
    endcase
  endfunction

  function automatic logic [7:0] modelRead(input logic [15:0] a);
    if (a < 16'h4000) return ramModel[a[13:0]];
    if (a < 16'hC000) return cartData;
    if (a[15:8] == AnticPage) begin
      case (a[7:0])
        8'h0B: return vcountQ;
        8'h0C: return penhQ;
        8'h0D: return penvQ;
        8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h07, 8'h09, 8'h0A, 8'h0E, 8'h0F:
          return anticShadow[a[3:0]];
        default: return 8'h00;
      endcase
    end
    if (a[15:8] == PokeyPage) return pokeyRead(a[7:0]);
    return 8'h00; // Nobody claims it
  endfunction

  // Reference model updated at the same edge as the DUT
  always @(posedge Fclk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        anticShadow[i] = 8'h00;
        pokeyShadow[i] = 8'h00;
      end
      vcountQ = 8'h00;
      penhQ   = 8'h00;
      penvQ   = 8'h00;
      for (int i = 0; i < NumStrobes; i++) strobeCnt[i] = 0;
      expRd = 8'h00;
    end else begin
      expRd = modelRead(cpu.addr.raw); // Old register state
      if (cpu.write && cpu.addr.raw < 16'h4000) expRd = cpu.wrData; // Write-first RAM
      case (anticChip.update) // Chip side first so the CPU write below overrides it
        3'd1: anticShadow[2] = anticChip.dlistl;
        3'd2: begin
          anticShadow[2] = anticChip.dlistl;
          anticShadow[3] = anticChip.dlisth;
        end
        3'd4: begin
          anticShadow[2]  = anticChip.dlistl;
          anticShadow[15] = anticChip.nmist;
        end
        3'd5: begin
          anticShadow[2]  = anticChip.dlistl;
          anticShadow[3]  = anticChip.dlisth;
          anticShadow[15] = anticChip.nmist;
        end
        3'd6: anticShadow[15] = anticChip.nmist;
        default: ;
      endcase
      if (cpu.write && cpu.addr.raw < 16'h4000) ramModel[cpu.addr.raw[13:0]] = cpu.wrData;
      if (cpu.write && cpu.addr.raw[15:8] == AnticPage &&
          cpu.addr.raw[7:0] inside {8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05,
                                    8'h07, 8'h09, 8'h0A, 8'h0E, 8'h0F})
        anticShadow[cpu.addr.raw[3:0]] = cpu.wrData;
      if (cpu.write && cpu.addr.raw[15:8] == PokeyPage &&
          cpu.addr.raw[7:0] inside {[8'h00:8'h08], 8'h0A, 8'h0D, 8'h0E, 8'h0F})
        pokeyShadow[cpu.addr.raw[3:0]] = cpu.wrData;
      // POTGO at E80B, STIMER at E809
      if (cpu.write && cpu.addr.raw == 16'hE80B) strobeCnt[StrobePotgo] = StrobeCycles;
      else if (strobeCnt[StrobePotgo] > 0) strobeCnt[StrobePotgo]--;
      if (cpu.write && cpu.addr.raw == 16'hE809) strobeCnt[StrobeStimer] = StrobeCycles;
      else if (strobeCnt[StrobeStimer] > 0) strobeCnt[StrobeStimer]--;
      vcountQ = anticChip.vcount;
      penhQ   = anticChip.penh;
      penvQ   = anticChip.penv;
    end
    expAntic.dmactl = anticShadow[0];
    expAntic.chactl = anticShadow[1];
    expAntic.dlistl = anticShadow[2];
    expAntic.dlisth = anticShadow[3];
    expAntic.hscrol = anticShadow[4];
    expAntic.vscrol = anticShadow[5];
    expAntic.pmbase = anticShadow[7];
    expAntic.chbase = anticShadow[9];
    expAntic.wsync  = anticShadow[10];
    expAntic.nmien  = anticShadow[14];
    expAntic.nmist  = anticShadow[15];
    expPokey.audf1  = pokeyShadow[0];
    expPokey.audc1  = pokeyShadow[1];
    expPokey.audf2  = pokeyShadow[2];
    expPokey.audc2  = pokeyShadow[3];
    expPokey.audf3  = pokeyShadow[4];
    expPokey.audc3  = pokeyShadow[5];
    expPokey.audf4  = pokeyShadow[6];
    expPokey.audc4  = pokeyShadow[7];
    expPokey.audctl = pokeyShadow[8];
    expPokey.skrest = pokeyShadow[10];
    expPokey.serout = pokeyShadow[13];
    expPokey.irqen  = pokeyShadow[14];
    expPokey.skctl  = pokeyShadow[15];
    for (int i = 0; i < NumStrobes; i++) expStrobes[i] = strobeCnt[i] != 0;
  end

  rdDataOk: assert property (@(posedge Fclk) disable iff (rst) rdData === expRd)
    else begin
      $display("FAILED time %0t rdData got %h expected %h", $time, $sampled(rdData),
               $sampled(expRd));
      abortRun();
    end

  anticRegsOk: assert property (@(posedge Fclk) disable iff (rst) anticRegs === expAntic)
    else begin
      $display("FAILED time %0t anticRegs got %h expected %h", $time, $sampled(anticRegs),
               $sampled(expAntic));
      abortRun();
    end

  pokeyRegsOk: assert property (@(posedge Fclk) disable iff (rst) pokeyRegs === expPokey)
    else begin
      $display("FAILED time %0t pokeyRegs got %h expected %h", $time, $sampled(pokeyRegs),
               $sampled(expPokey));
      abortRun();
    end

  strobesOk: assert property (@(posedge Fclk) disable iff (rst) strobes === expStrobes)
    else begin
      $display("FAILED time %0t strobes got %b expected %b", $time, $sampled(strobes),
               $sampled(expStrobes));
      abortRun();
    end

  always @(posedge Fclk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: stimulus still running after %0d cycles", TimeoutCycles);
      abortRun();
    end
  end

  // One bus cycle with fresh random chip-side inputs
  task automatic driveCycle(input logic [15:0] addr, input logic wr, input logic [7:0] data,
                            input logic [2:0] code);
    logic [31:0] r;
    @(posedge Fclk);
    #1;
    cpu.addr.raw = addr;
    cpu.write    = wr;
    cpu.wrData   = data;
    randBits(8, r);
    cartData = r[7:0];
    randBits(24, r);
    anticChip.vcount = r[23:16];
    anticChip.penh   = r[15:8];
    anticChip.penv   = r[7:0];
    randBits(24, r);
    anticChip.dlistl = r[23:16];
    anticChip.dlisth = r[15:8];
    anticChip.nmist  = r[7:0];
    anticChip.update = code;
  endtask

  task automatic newPokeyIn();
    logic [31:0] r;
    for (int i = 0; i < 14; i++) begin
      randBits(8, r);
      pokeyIn[i*8 +: 8] = r[7:0];
    end
  endtask

  // 128 RAM addresses at both ends of the 16 K
  function automatic logic [15:0] ramWindow(input logic [6:0] idx);
    return {2'b00, idx[6] ? 8'hFF : 8'h00, idx[5:0]};
  endfunction

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [15:0] a;
    rst       = 1'b1;
    cpu       = '0;
    cartData  = '0;
    anticChip = '0;
    pokeyIn   = '0;
    repeat (5) @(posedge Fclk);
    #1 rst = 1'b0;

    for (int i = 0; i < 128; i++) begin // Fill the window
      randBits(8, d);
      driveCycle(ramWindow(i[6:0]), 1'b1, d[7:0], AnticNone);
    end
    for (int i = 0; i < 400; i++) begin // Random RAM traffic
      randBits(8, r);
      randBits(8, d);
      driveCycle(ramWindow(r[6:0]), r[7], d[7:0], AnticNone);
    end
    for (int i = 0; i < 120; i++) begin // Cartridge space aliasing the RAM window
      randBits(9, r);
      randBits(8, d);
      a = ramWindow(r[6:0]) | (r[7] ? 16'h4000 : 16'h8000);
      driveCycle(a, r[8], d[7:0], AnticNone);
    end
    for (int i = 0; i < 128; i++) driveCycle(ramWindow(i[6:0]), 1'b0, 8'h00, AnticNone);

    newPokeyIn();
    for (int p = 0; p < 2; p++) begin // Every offset of both pages
      for (int o = 0; o < 16; o++) begin
        randBits(8, d);
        driveCycle({p ? PokeyPage : AnticPage, 4'h0, o[3:0]}, 1'b1, d[7:0], AnticNone);
      end
      for (int o = 0; o < 16; o++)
        driveCycle({p ? PokeyPage : AnticPage, 4'h0, o[3:0]}, 1'b0, 8'h00, AnticNone);
    end
    for (int i = 0; i < 200; i++) begin // Random register space including unclaimed pages
      if (i % 16 == 0) newPokeyIn();
      randBits(17, r);
      randBits(8, d);
      case (r[1:0])
        2'd0: a = {AnticPage, 3'b000, r[6:2]};
        2'd1: a = {PokeyPage, 3'b000, r[6:2]};
        default: a = {2'b11, r[12:7], 3'b000, r[6:2]};
      endcase
      driveCycle(a, r[13], d[7:0], r[16:14]);
    end

    for (int c = 0; c < 8; c++) begin // Each update code alone and against a CPU write
      for (int t = 0; t < 4; t++) begin
        randBits(8, d);
        case (t)
          0: driveCycle(16'hD40B, 1'b0, 8'h00, c[2:0]);
          1: driveCycle(16'hD402, 1'b1, d[7:0], c[2:0]);
          2: driveCycle(16'hD403, 1'b1, d[7:0], c[2:0]);
          default: driveCycle(16'hD40F, 1'b1, d[7:0], c[2:0]);
        endcase
        driveCycle(16'hD402, 1'b0, 8'h00, AnticNone);
        driveCycle(16'hD403, 1'b0, 8'h00, AnticNone);
        driveCycle(16'hD40F, 1'b0, 8'h00, AnticNone);
      end
    end

    driveCycle(16'hE80B, 1'b1, 8'h00, AnticNone); // POTGO alone
    repeat (12) driveCycle(16'hE80A, 1'b0, 8'h00, AnticNone);
    driveCycle(16'hE809, 1'b1, 8'h00, AnticNone); // STIMER and then a restart
    repeat (4) driveCycle(16'hE80A, 1'b0, 8'h00, AnticNone);
    driveCycle(16'hE809, 1'b1, 8'h00, AnticNone);
    repeat (12) driveCycle(16'hE80A, 1'b0, 8'h00, AnticNone);
    driveCycle(16'hE80B, 1'b1, 8'h00, AnticNone);
    driveCycle(16'hE80B, 1'b1, 8'h00, AnticNone); // Back to back
    driveCycle(16'hE809, 1'b1, 8'h00, AnticNone);
    repeat (12) driveCycle(16'hE80A, 1'b0, 8'h00, AnticNone);

    repeat (2) @(posedge Fclk);
    #1;
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: memoryMap.f
hdl/memMapPkg.sv
hdl/workRam.sv
hdl/strobeStretcher.sv
hdl/busSteer.sv
hdl/anticRegs.sv
hdl/pokeyRegs.sv
hdl/memoryMap.sv
tests/memoryMapTb.sv

// File: Bender.yml
package:
  name: memoryMap

sources:
  - hdl/memMapPkg.sv
  - hdl/workRam.sv
  - hdl/strobeStretcher.sv
  - hdl/busSteer.sv
  - hdl/anticRegs.sv
  - hdl/pokeyRegs.sv
  - hdl/memoryMap.sv
  - target: simulation
    files:
      - tests/memoryMapTb.sv
